//--- verification/bypassLsu_stim.txt
# op addr data wmask size sqN tag ext brTaken brSqN hold expData (hex except wmask, size, flags, hold)
# Fields an op does not use are zero. Hold is the largest resStall hold in cycles.
st      00000010 a5b6c7d8 1111 0 00 00 0 0 00 0 00000000
ld      00000010 00000000 0000 2 05 11 0 0 00 0 a5b6c7d8
st      00000011 00005500 0010 0 00 00 0 0 00 0 00000000
st      00000012 12340000 1100 0 00 00 0 0 00 0 00000000
ld      00000010 00000000 0000 2 06 12 0 0 00 0 123455d8
ld      00000011 00000000 0000 0 07 13 0 0 00 3 55555555
ld      00000012 00000000 0000 1 08 14 0 0 00 4 12341234
ld      00000010 00000000 0000 0 09 15 0 0 00 0 d8d8d8d8
ld      00000013 00000000 0000 0 0a 16 0 0 00 2 12121212
stld    00000020 cafef00d 1111 2 0b 17 0 0 00 0 cafef00d
ld      00000020 00000000 0000 2 0c 18 0 0 00 6 cafef00d
ld      00000020 00000000 0000 2 12 19 0 1 10 0 00000000
ld      00000020 00000000 0000 2 12 1a 1 1 10 0 cafef00d
ld      00000020 00000000 0000 1 0e 1b 0 1 10 2 f00df00d
ldflush 00000020 00000000 0000 2 14 1c 0 1 10 3 00000000
ldflush 00000022 00000000 0000 1 0f 1d 0 1 10 0 cafecafe
ld      00000020 00000000 0000 2 01 1e 0 1 7e 0 00000000
stld    00000026 00bc0000 0100 0 02 1f 0 0 00 5 bcbcbcbc

//--- src.f
+incdir+logic
logic/lsuPkg.sv
logic/memcIf.sv
logic/bypassLsu.sv
logic/memController.sv
logic/bypassLsuTop.sv
verification/bypassLsuChecker.sv
verification/bypassLsu_assert.sv
verification/bypassLsuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= bypassLsuTb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f src.f
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/bypassLsuTb.sv
`timescale 1ns/100ps
`include "bypassLsu_defines.svh"

module bypassLsuTb;

    logic clk = 1'b0;
    logic rst, branchTaken, ldEn, ldValid, ldExternal, ldStall, stEn, stValid, stStall;
    logic resStall, resValid, testDone, expResult, loaded;
    logic [`SQN_W-1:0] branchSqN, ldSqN, resSqN, expSqN;
    logic [`TAG_W-1:0] ldTag, resTag, expTag;
    logic [`XLEN-1:0] ldAddr, stAddr, stData, resData, expData;
    logic [1:0] ldSize;
    logic [3:0] stWmask;
    int errors, tests, badLines;
    int seed = 32'h732c462a;
    string lines[$];

    always #5 clk = ~clk;

    bypassLsuTop dut0 (.*);

    bypassLsuChecker chk0 (.*);

    // Younger means the signed sqN difference is above zero.
    function automatic logic isYounger(input logic [`SQN_W-1:0] sqN,
                                       input logic [`SQN_W-1:0] brSqN);
        logic [`SQN_W-1:0] diff;
        diff = sqN - brSqN;
        return (diff != 0) && !diff[`SQN_W-1];
    endfunction

    task automatic runLine(input string line);
        string op;
        logic [31:0] addr, data, exp;
        logic [3:0] wmask;
        int size, sqN, tag, ext, brTaken, brSqN, holdMax, holdLeft, n;
        logic isLd, isSt;
        n = $sscanf(line, "%s %h %h %b %d %h %h %d %d %h %d %h", op, addr, data, wmask,
                    size, sqN, tag, ext, brTaken, brSqN, holdMax, exp);
        if (n != 12) begin
            $display("ERROR: unreadable stimulus line: %s", line);
            badLines++;
        end else begin
            isSt = (op == "st") || (op == "stld");
            isLd = (op == "ld") || (op == "ldflush") || (op == "stld");
            ldAddr = addr;
            ldSize = size[1:0];
            ldSqN = sqN[`SQN_W-1:0];
            ldTag = tag[`TAG_W-1:0];
            ldExternal = ext[0];
            stAddr = addr;
            stData = data;
            stWmask = wmask;
            stEn = isSt;
            stValid = isSt;
            ldEn = isLd;
            ldValid = isLd;
            branchSqN = brSqN[`SQN_W-1:0];
            branchTaken = brTaken[0] && (op != "ldflush"); // A flush arrives in flight.
            expResult = isLd && !(brTaken[0] && !ext[0]
                                  && isYounger(sqN[`SQN_W-1:0], brSqN[`SQN_W-1:0]));
            expTag = tag[`TAG_W-1:0];
            expSqN = sqN[`SQN_W-1:0];
            expData = exp;
            holdLeft = (holdMax > 0) ? 1 + int'($unsigned($random(seed)) % holdMax) : 0;
            resStall = (holdLeft > 0);
            @(negedge clk);
            if (isSt) begin
                stEn = 1'b0;
                stValid = 1'b0;
                while (stStall) @(negedge clk);
                if (isLd) @(negedge clk); // The load goes in once the store is done.
            end
            if (isLd) begin
                ldEn = 1'b0;
                ldValid = 1'b0;
                if (op == "ldflush") branchTaken = brTaken[0];
                while (ldStall) begin
                    if (resValid) begin
                        resStall = (holdLeft > 0);
                        if (holdLeft > 0) holdLeft--;
                    end
                    @(negedge clk);
                end
            end
        end
        branchTaken = 1'b0;
        resStall = 1'b0;
        testDone = 1'b1;
        @(negedge clk);
        testDone = 1'b0;
    endtask

    initial begin
        int fd;
        int total;
        string line;
        {rst, branchTaken, ldEn, ldValid, ldExternal, stEn, stValid} = 7'b1000000;
        {resStall, testDone, expResult, loaded} = 4'b0000;
        {branchSqN, ldSqN, expSqN, ldTag, expTag, ldSize, stWmask} = '0;
        {ldAddr, stAddr, stData, expData} = '0;
        badLines = 0;
        fd = $fopen("verification/bypassLsu_stim.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the stimulus file could not be opened");
            badLines++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") lines.push_back(line);
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (lines[i]) runLine(lines[i]);
        repeat (2) @(negedge clk);
        total = errors + badLines + dut0.assert0.failCount;
        $display("Tests run: %0d, errors: %0d", tests, total);
        if (total == 0 && tests > 0) $display("Simulation passed");
        else $display("Simulation failed");
        $finish;
    end

    // Budget per line covers the memory latency plus stalls and hold time.
    initial begin
        wait (loaded);
        #((lines.size() * (`MEMC_LATENCY + 20) + 20) * 10);
        $display("ERROR: watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verification/bypassLsu_assert.sv
`timescale 1ns/100ps
`include "bypassLsu_defines.svh"

module bypassLsuAssert (
    input logic clk,
    input logic rst,
    input logic stStall,
    input logic ldStall,
    input logic resStall,
    input logic resValid,
    input logic [`TAG_W-1:0] resTag,
    input logic [`XLEN-1:0] resData
);

    int failCount = 0; // Read by the testbench at the end of the run.

    stallOrder: assert property (@(posedge clk) disable iff (rst) stStall |-> ldStall)
        else begin $error("stStall high while ldStall is low"); failCount++; end

    resultHoldsStall: assert property (@(posedge clk) disable iff (rst) resValid |-> ldStall)
        else begin $error("resValid high while ldStall is low"); failCount++; end

    // A stalled result must not move.
    resultStable: assert property (@(posedge clk) disable iff (rst)
        (resValid && resStall) |=> (resValid && $stable(resData) && $stable(resTag)))
        else begin $error("result changed while resStall was high"); failCount++; end

    resetClears: assert property (@(posedge clk) $past(rst) |-> !resValid)
        else begin $error("resValid high during reset"); failCount++; end

endmodule

bind bypassLsuTop bypassLsuAssert assert0 (
    .clk(clk), .rst(rst), .stStall(stStall), .ldStall(ldStall), .resStall(resStall),
    .resValid(resValid), .resTag(resTag), .resData(resData)
);

//--- verification/bypassLsuChecker.sv
`timescale 1ns/100ps
`include "bypassLsu_defines.svh"

module bypassLsuChecker (
    input logic clk,
    input logic rst,
    input logic stValid,
    input logic ldStall,
    input logic stStall,
    input logic resStall,
    input logic resValid,
    input logic [`TAG_W-1:0] resTag,
    input logic [`SQN_W-1:0] resSqN,
    input logic [`XLEN-1:0] resData,
    input logic testDone,
    input logic expResult,
    input logic [`TAG_W-1:0] expTag,
    input logic [`SQN_W-1:0] expSqN,
    input logic [`XLEN-1:0] expData,
    output int errors,
    output int tests
);

    int seen;
    int errStart;
    logic held;
    logic [`XLEN-1:0] heldData;

    task automatic mismatch(input string name, input logic [31:0] expV, input logic [31:0] actV);
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expV, actV);
        errors++;
    endtask

    task automatic fault(input string what);
        $display("ERROR at %0t: %s", $time, what);
        errors++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            errors = 0;
            tests = 0;
            seen = 0;
            errStart = 0;
            held = 1'b0;
        end else begin
            if (stValid && !ldStall) fault("load not stalled while a store is waiting");
            if (!stValid && stStall !== ldStall) begin
                fault("stStall and ldStall differ with no store waiting");
            end
            if (held && !resValid) fault("result dropped while resStall was high");
            else if (held && resData !== heldData) mismatch("resData", heldData, resData);
            held = resValid && resStall;
            heldData = resData;
            if (resValid && !resStall) begin // Writeback takes the result on this edge.
                seen++;
                if (!expResult) begin
                    fault("result returned for a squashed load");
                end else begin
                    if (resTag !== expTag) mismatch("resTag", 32'(expTag), 32'(resTag));
                    if (resSqN !== expSqN) mismatch("resSqN", 32'(expSqN), 32'(resSqN));
                    if (resData !== expData) mismatch("resData", expData, resData);
                end
            end
            if (testDone) begin
                tests++;
                if (seen != (expResult ? 1 : 0)) fault($sformatf("saw %0d results", seen));
                $display("test %0d: %s", tests, (errors == errStart) ? "ok" : "FAIL");
                seen = 0;
                errStart = errors;
            end
        end
    end

endmodule

//--- logic/bypassLsuTop.sv
`timescale 1ns/100ps
`include "bypassLsu_defines.svh"

module bypassLsuTop import lsuPkg::*; (
    input logic clk,
    input logic rst,
    input logic branchTaken,
    input logic [`SQN_W-1:0] branchSqN,
    input logic ldEn,
    input logic ldValid,
    input logic [`XLEN-1:0] ldAddr,
    input logic [1:0] ldSize,
    input logic [`SQN_W-1:0] ldSqN,
    input logic [`TAG_W-1:0] ldTag,
    input logic ldExternal,
    output logic ldStall,
    input logic stEn,
    input logic stValid,
    input logic [`XLEN-1:0] stAddr,
    input logic [`XLEN-1:0] stData,
    input logic [3:0] stWmask,
    output logic stStall,
    input logic resStall,
    output logic resValid,
    output logic [`TAG_W-1:0] resTag,
    output logic [`SQN_W-1:0] resSqN,
    output logic [`XLEN-1:0] resData
);

    BranchProv branch;
    LdUop ldUop;
    StUop stUop;
    LdUop resUop;

    memcIf memcBus ();

    assign branch = '{taken: branchTaken, sqN: branchSqN};
    assign ldUop = '{valid: ldValid, addr: ldAddr, size: ldSize, sqN: ldSqN,
                     tagDst: ldTag, external: ldExternal};
    assign stUop = '{valid: stValid, addr: stAddr, data: stData, wmask: stWmask};

    assign resValid = resUop.valid;
    assign resTag = resUop.tagDst;
    assign resSqN = resUop.sqN;

    bypassLsu lsu0 (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .ldEn(ldEn),
        .ldUop(ldUop),
        .ldStall(ldStall),
        .stEn(stEn),
        .stUop(stUop),
        .stStall(stStall),
        .resStall(resStall),
        .resUop(resUop),
        .resData(resData),
        .memc(memcBus.lsu)
    );

    memController memc0 (
        .clk(clk),
        .rst(rst),
        .memc(memcBus.memc)
    );

endmodule

//--- logic/memController.sv
`timescale 1ns/100ps
`include "bypassLsu_defines.svh"

module memController import lsuPkg::*; (
    input logic clk,
    input logic rst,
    memcIf.memc memc
);

    localparam int WA_W = $clog2(`MEM_WORDS);
    localparam int CNT_W = $clog2(`MEMC_LATENCY + 1);

    logic [`XLEN-1:0] mem [`MEM_WORDS];
    MemcReq reqQ;
    logic busy;
    logic [CNT_W-1:0] cnt;
    logic ldValid;
    logic stValid;
    logic [`XLEN-1:0] ldData;
    logic accept;
    logic finish;
    logic isWrite;
    logic [3:0] byteEn;
    logic [WA_W-1:0] wordAddr;
    logic [1:0] offset;
    logic [`XLEN-1:0] rdWord;
    logic [`XLEN-1:0] rdLanes;

    assign accept = !busy && (memc.req.cmd != NONE);
    assign finish = busy && (cnt == '0);
    assign wordAddr = reqQ.addr[WA_W+1:2];
    assign offset = reqQ.addr[1:0];
    assign rdWord = mem[wordAddr];
    assign isWrite = reqQ.cmd inside {WRITE_BYTE, WRITE_HALF, WRITE_WORD};

    always_comb begin
        case (reqQ.cmd)
            WRITE_BYTE: byteEn = 4'b0001 << offset;
            WRITE_HALF: byteEn = offset[1] ? 4'b1100 : 4'b0011;
            WRITE_WORD: byteEn = 4'b1111;
            default: byteEn = 4'b0000;
        endcase
    end

    // Narrow reads come back in the low lanes.
    always_comb begin
        rdLanes = '0;
        case (reqQ.cmd)
            READ_BYTE: rdLanes[7:0] = rdWord[8*offset +: 8];
            READ_HALF: rdLanes[15:0] = rdWord[16*offset[1] +: 16];
            default: rdLanes = rdWord;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt <= '0;
            ldValid <= 1'b0;
            stValid <= 1'b0;
        end else begin
            ldValid <= 1'b0;
            stValid <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt <= CNT_W'(`MEMC_LATENCY - 1);
            end else if (finish) begin
                busy <= 1'b0;
                ldValid <= !isWrite;
                stValid <= isWrite;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) reqQ <= memc.req;
        if (finish) begin
            ldData <= rdLanes;
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) mem[wordAddr][8*i +: 8] <= reqQ.data[8*i +: 8];
            end
        end
    end

    assign memc.res = '{ldValid: ldValid, ldData: ldData, stValid: stValid, stall: busy};

endmodule

//--- logic/bypassLsu.sv
`timescale 1ns/100ps
`include "bypassLsu_defines.svh"

module bypassLsu import lsuPkg::*; (
    input logic clk,
    input logic rst,
    input BranchProv branch,
    input logic ldEn,
    input LdUop ldUop,
    output logic ldStall,
    input logic stEn,
    input StUop stUop,
    output logic stStall,
    input logic resStall,
    output LdUop resUop,
    output logic [`XLEN-1:0] resData,
    memcIf.lsu memc
);

    typedef enum logic [2:0] {
        IDLE,
        RQ_LD,
        RQ_ST,
        WAIT_LD,
        WAIT_ST,
        DONE_LD
    } State;

    State state;
    LdUop activeLd;
    logic [1:0] stOffset;
    logic stAccept;
    logic ldAccept;
    logic activeSquash;

    // A micro-op dies when it is younger than a taken branch and not external.
    function automatic logic isSquashed(input BranchProv br, input logic [`SQN_W-1:0] sqN,
                                        input logic external);
        logic [`SQN_W-1:0] diff;
        diff = sqN - br.sqN;
        return br.taken && !external && ($signed(diff) > 0);
    endfunction

    assign stStall = (state != IDLE);
    assign ldStall = (state != IDLE) || stUop.valid; // A waiting store goes first.

    assign stAccept = stEn && stUop.valid && !stStall;
    assign ldAccept = ldEn && ldUop.valid && !ldStall
                      && !isSquashed(branch, ldUop.sqN, ldUop.external);
    assign activeSquash = isSquashed(branch, activeLd.sqN, activeLd.external);

    // Lowest set lane of the write mask gives the byte offset.
    always_comb begin
        stOffset = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (stUop.wmask[i]) stOffset = 2'(i);
        end
    end

    always_comb begin
        resUop = activeLd;
        resUop.valid = (state == DONE_LD) && activeLd.valid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            activeLd.valid <= 1'b0;
            memc.req.cmd <= NONE;
        end else begin
            if (activeSquash) activeLd.valid <= 1'b0; // Access still finishes, result is dropped.
            case (state)
                IDLE: begin
                    if (stAccept) begin
                        case (stUop.wmask)
                            4'b0001, 4'b0010, 4'b0100, 4'b1000: memc.req.cmd <= WRITE_BYTE;
                            4'b0011, 4'b1100: memc.req.cmd <= WRITE_HALF;
                            default: memc.req.cmd <= WRITE_WORD;
                        endcase
                        memc.req.addr <= {stUop.addr[`XLEN-1:2], stOffset};
                        memc.req.data <= stUop.data;
                        state <= RQ_ST;
                    end else if (ldAccept) begin
                        case (ldUop.size)
                            2'd0: memc.req.cmd <= READ_BYTE;
                            2'd1: memc.req.cmd <= READ_HALF;
                            default: memc.req.cmd <= READ_WORD;
                        endcase
                        memc.req.addr <= ldUop.addr;
                        activeLd <= ldUop;
                        state <= RQ_LD;
                    end
                end
                RQ_LD, RQ_ST: begin
                    if (!memc.res.stall) begin
                        memc.req.cmd <= NONE; // Controller latches the request on this edge.
                        state <= (state == RQ_LD) ? WAIT_LD : WAIT_ST;
                    end
                end
                WAIT_LD: begin
                    if (memc.res.ldValid) begin
                        case (activeLd.size)
                            2'd0: resData <= {(`XLEN/8){memc.res.ldData[7:0]}};
                            2'd1: resData <= {(`XLEN/16){memc.res.ldData[15:0]}};
                            default: resData <= memc.res.ldData;
                        endcase
                        state <= DONE_LD;
                    end
                end
                WAIT_ST: begin
                    if (memc.res.stValid) state <= IDLE;
                end
                DONE_LD: begin
                    if (!resStall || !activeLd.valid) begin
                        activeLd.valid <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- logic/memcIf.sv
`timescale 1ns/100ps

interface memcIf import lsuPkg::*;
();

    MemcReq req; // Held until the controller drops stall.
    MemcRes res;

    modport lsu (
        output req,
        input res
    );

    modport memc (
        input req,
        output res
    );

endinterface

//--- logic/lsuPkg.sv
`include "bypassLsu_defines.svh"

package lsuPkg;

    typedef enum logic [2:0] {
        NONE,
        READ_BYTE,
        READ_HALF,
        READ_WORD,
        WRITE_BYTE,
        WRITE_HALF,
        WRITE_WORD
    } MemcCmd;

    typedef struct packed {
        logic valid;
        logic [`XLEN-1:0] addr;
        logic [1:0] size; // 0 byte, 1 half, 2 word.
        logic [`SQN_W-1:0] sqN;
        logic [`TAG_W-1:0] tagDst;
        logic external; // Never squashed by a branch.
    } LdUop;

    typedef struct packed {
        logic valid;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data; // Already placed in its byte lanes.
        logic [3:0] wmask;
    } StUop;

    typedef struct packed {
        logic taken;
        logic [`SQN_W-1:0] sqN;
    } BranchProv;

    typedef struct packed {
        MemcCmd cmd;
        logic [`XLEN-1:0] addr; // Word address above bit 1, byte offset below.
        logic [`XLEN-1:0] data;
    } MemcReq;

    typedef struct packed {
        logic ldValid;
        logic [`XLEN-1:0] ldData;
        logic stValid;
        logic stall;
    } MemcRes;

endpackage

//--- logic/bypassLsu_defines.svh
`ifndef BYPASS_LSU_DEFINES_SVH
`define BYPASS_LSU_DEFINES_SVH

`define XLEN 32 // Data and address width.
`define SQN_W 7 // Store sequence number width.
`define TAG_W 6 // Destination tag width.
`define MEM_WORDS 256 // SRAM depth in words.
`define MEMC_LATENCY 3 // Cycles from acceptance to the response pulse.

`endif
